/* Makefile */
VERILATOR ?= verilator
TOP       := smpc_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* source/smpc_bus_pkg.sv */
package smpc_bus_pkg;

	typedef logic [5:0] bus_addr_t;
	typedef logic [7:0] bus_data_t;
	typedef logic [4:0] oreg_addr_t;

	// Odd byte addresses, {A, 1'b1}
	typedef enum logic [6:0] {
		REG_IREG0  = 7'h01,
		REG_IREG1  = 7'h03,
		REG_IREG2  = 7'h05,
		REG_IREG3  = 7'h07,
		REG_IREG4  = 7'h09,
		REG_IREG5  = 7'h0B,
		REG_IREG6  = 7'h0D,
		REG_COMREG = 7'h1F,
		REG_SR     = 7'h61,
		REG_SF     = 7'h63
	} reg_addr_e;

endpackage

/* source/smpc_cmd_pkg.sv */
package smpc_cmd_pkg;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_code_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_COMMAND,
		ST_EXEC,
		ST_END
	} seq_state_e;

	typedef logic [15:0] wait_cnt_t;

	typedef logic [7:0]  bcd_byte_t;   // Two BCD digits
	typedef logic [15:0] bcd_year_t;   // Four BCD digits
	typedef logic [3:0]  nibble_t;

endpackage

/* source/smpc_cmd_seq.sv */
`include "smpc_defines.svh"

module smpc_cmd_seq (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ce,
	input  smpc_cmd_pkg::nibble_t ac,
	smpc_cmd_if.seq               cmd,
	smpc_rtc_if.seq               rtc,
	output logic [4:0]            oreg_wa,
	output logic [7:0]            oreg_wd,
	output logic                  oreg_we,
	output logic                  mshres_n,
	output logic                  mshnmi_n,
	output logic                  sshres_n,
	output logic                  sshnmi_n,
	output logic                  sndres_n,
	output logic                  cdres_n,
	output logic                  mirq_n
);
	import smpc_cmd_pkg::*;

	seq_state_e state;
	seq_state_e next_state;   // Where WAIT goes on expiry
	wait_cnt_t  wait_cnt;
	cmd_code_e  code;
	logic       intback_ok;
	logic [4:0] oreg_cnt;
	logic       resd;
	logic [7:0] intback_byte;

	// Status-mode INTBACK result bytes
	always_comb begin
		case (oreg_cnt)
			5'd0:  intback_byte = {1'b0, resd, 6'b000000};
			5'd1:  intback_byte = rtc.year[15:8];
			5'd2:  intback_byte = rtc.year[7:0];
			5'd3:  intback_byte = rtc.weekday_month;
			5'd4:  intback_byte = rtc.days;
			5'd5:  intback_byte = rtc.hour;
			5'd6:  intback_byte = rtc.min;
			5'd7:  intback_byte = rtc.sec;
			5'd9:  intback_byte = {4'b0000, ac};
			5'd10: intback_byte = {2'b00, 2'b11, ~mshnmi_n, 1'b1, 1'b0, ~sndres_n};
			5'd11: intback_byte = {1'b0, ~cdres_n, 6'b000000};
			5'(`SMPC_OREG_LAST): intback_byte = code;
			default: intback_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state            <= ST_IDLE;
			next_state       <= ST_IDLE;
			wait_cnt         <= '0;
			code             <= CMD_MSHON;
			intback_ok       <= 1'b0;
			oreg_cnt         <= '0;
			oreg_wa          <= '0;
			oreg_wd          <= '0;
			oreg_we          <= 1'b0;
			cmd.cmd_ack      <= 1'b0;
			cmd.cmd_done     <= 1'b0;
			cmd.intback_done <= 1'b0;
			mshres_n         <= 1'b0;
			mshnmi_n         <= 1'b0;
			sshres_n         <= 1'b0;
			sshnmi_n         <= 1'b0;
			sndres_n         <= 1'b0;
			cdres_n          <= 1'b0;
			mirq_n           <= 1'b1;
			resd             <= 1'b1;
		end else begin
			cmd.cmd_done     <= 1'b0;
			cmd.intback_done <= 1'b0;
			oreg_we          <= 1'b0;
			mirq_n           <= 1'b1;

			if (cmd.cmd_ack && !cmd.cmd_req)
				cmd.cmd_ack <= 1'b0;   // Phase 4

			if (ce) begin
				case (state)
					ST_IDLE: begin
						if (cmd.cmd_req && !cmd.cmd_ack) begin
							cmd.cmd_ack <= 1'b1;
							code        <= cmd.comreg;
							intback_ok  <= (cmd.ireg2 == 8'hF0) && cmd.ireg0[0];
							wait_cnt    <= wait_cnt_t'(`SMPC_WAIT_COMMAND);
							next_state  <= ST_COMMAND;
							state       <= ST_WAIT;
						end
					end

					ST_WAIT: begin
						if (wait_cnt == '0)
							state <= next_state;
						else
							wait_cnt <= wait_cnt - 16'd1;
					end

					ST_COMMAND: begin
						next_state <= ST_EXEC;
						state      <= ST_WAIT;
						oreg_cnt   <= '0;
						case (code)
							CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF:
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_POWER);
							CMD_CDON, CMD_CDOFF:
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_CD);
							CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA:
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_NMI);
							CMD_INTBACK: begin
								if (intback_ok)
									wait_cnt <= wait_cnt_t'(`SMPC_WAIT_INTBACK);
								else
									state <= ST_END;   // Nothing written
							end
							default: state <= ST_EXEC;
						endcase
					end

					ST_EXEC: begin
						oreg_we <= 1'b1;
						oreg_wa <= 5'(`SMPC_OREG_LAST);
						oreg_wd <= code;
						state   <= ST_END;
						case (code)
							CMD_MSHON: begin
								mshres_n <= 1'b1;
								mshnmi_n <= 1'b1;
							end
							CMD_SSHON: begin
								sshres_n <= 1'b1;
								sshnmi_n <= 1'b1;
							end
							CMD_SSHOFF: begin
								sshres_n <= 1'b0;
								sshnmi_n <= 1'b1;
							end
							CMD_SNDON:   sndres_n <= 1'b1;
							CMD_SNDOFF:  sndres_n <= 1'b0;
							CMD_CDON:    cdres_n <= 1'b1;
							CMD_CDOFF:   cdres_n <= 1'b0;
							CMD_NMIREQ:  mshnmi_n <= 1'b0;
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_INTBACK: begin
								// One OREG per CE cycle
								oreg_wa  <= oreg_cnt;
								oreg_wd  <= intback_byte;
								oreg_cnt <= oreg_cnt + 5'd1;
								state    <= ST_EXEC;
								if (oreg_cnt == 5'(`SMPC_OREG_LAST)) begin
									cmd.intback_done <= 1'b1;
									mirq_n           <= 1'b0;
									state            <= ST_END;
								end
							end
							default: ;
						endcase
					end

					ST_END: begin
						if (code == CMD_NMIREQ)
							mshnmi_n <= 1'b1;   // Release NMI
						cmd.cmd_done <= 1'b1;
						state        <= ST_IDLE;
					end

					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	a_ack_needs_req: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmd.cmd_ack) |-> cmd.cmd_req)
		else $error("cmd_ack rose without a pending cmd_req");

	a_oreg_we_exec: assert property (@(posedge CLK) disable iff (!RST_N)
		oreg_we |-> $past(state) == ST_EXEC)
		else $error("OREG write issued outside EXEC");

endmodule

/* source/smpc_defines.svh */
`ifndef SMPC_DEFINES_SVH
`define SMPC_DEFINES_SVH

// Wait counts, all in CE cycles
`define SMPC_WAIT_COMMAND 90
`define SMPC_WAIT_POWER 120
`define SMPC_WAIT_CD 159
`define SMPC_WAIT_NMI 127
`define SMPC_WAIT_INTBACK 800

// RTC prescaler default and reset year
`define SMPC_TICKS_PER_SEC 4000000
`define SMPC_RTC_YEAR_INIT 16'h2024

// Last OREG, holds the echoed command
`define SMPC_OREG_LAST 31

`endif

/* source/smpc_host_regs.sv */
module smpc_host_regs (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  smpc_bus_pkg::bus_addr_t  a,
	input  smpc_bus_pkg::bus_data_t  di,
	input  logic                     cs_n,
	input  logic                     rw_n,
	output smpc_bus_pkg::bus_data_t  rdata,
	output smpc_bus_pkg::oreg_addr_t oreg_ra,
	input  smpc_bus_pkg::bus_data_t  oreg_rd,
	smpc_cmd_if.host                 cmd
);
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	bus_data_t  ireg [7];
	bus_data_t  sr;
	logic       sf;
	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_stb;
	logic       rd_stb;
	logic [6:0] byte_addr;

	assign byte_addr = {a, 1'b1};
	assign wr_stb = !rw_n && rw_n_old && !cs_n;   // RW_N falling, chip selected
	assign rd_stb = !cs_n && cs_n_old && rw_n;    // CS_N falling on a read

	// OREG0 sits at byte 21
	assign oreg_ra = oreg_addr_t'(a - 6'h10);

	assign cmd.ireg0 = ireg[0];
	assign cmd.ireg1 = ireg[1];
	assign cmd.ireg2 = ireg[2];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old    <= 1'b1;
			cs_n_old    <= 1'b1;
			ireg        <= '{default: '0};
			sr          <= '0;
			sf          <= 1'b0;
			cmd.cmd_req <= 1'b0;
			cmd.comreg  <= CMD_MSHON;
			rdata       <= '0;
		end else begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;

			if (cmd.cmd_req && cmd.cmd_ack)
				cmd.cmd_req <= 1'b0;   // Phase 3
			if (cmd.cmd_done)
				sf <= 1'b0;
			if (cmd.intback_done)
				sr <= 8'h4F;

			if (wr_stb) begin
				case (byte_addr)
					REG_IREG0: ireg[0] <= di;
					REG_IREG1: ireg[1] <= di;
					REG_IREG2: ireg[2] <= di;
					REG_IREG3: ireg[3] <= di;
					REG_IREG4: ireg[4] <= di;
					REG_IREG5: ireg[5] <= di;
					REG_IREG6: ireg[6] <= di;
					REG_COMREG: begin
						// Dropped while a hand-off is still open
						if (!cmd.cmd_req && !cmd.cmd_ack) begin
							cmd.comreg  <= cmd_code_e'(di);
							cmd.cmd_req <= 1'b1;
						end
					end
					REG_SF: if (di[0]) sf <= 1'b1;
					default: ;
				endcase
			end

			if (rd_stb) begin
				if (byte_addr >= 7'h21 && byte_addr <= 7'h5F) begin
					rdata <= oreg_rd;
				end else begin
					case (byte_addr)
						REG_SR:  rdata <= sr;
						REG_SF:  rdata <= {7'b0000000, sf};
						default: rdata <= '0;
					endcase
				end
			end
		end
	end

	a_comreg_stable: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd.cmd_req |=> $stable(cmd.comreg))
		else $error("comreg changed during an open command request");

endmodule

/* source/smpc_if.sv */
// Command hand-off, host registers to sequencer
interface smpc_cmd_if;
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	logic      cmd_req;
	cmd_code_e comreg;
	bus_data_t ireg0;
	bus_data_t ireg1;
	bus_data_t ireg2;
	logic      cmd_ack;
	logic      cmd_done;       // One-cycle strobe, clears SF
	logic      intback_done;   // One-cycle strobe, sets SR

	modport host (
		output cmd_req, comreg, ireg0, ireg1, ireg2,
		input  cmd_ack, cmd_done, intback_done
	);

	modport seq (
		input  cmd_req, comreg, ireg0, ireg1, ireg2,
		output cmd_ack, cmd_done, intback_done
	);
endinterface

interface smpc_rtc_if;
	import smpc_cmd_pkg::*;

	bcd_byte_t sec;
	bcd_byte_t min;
	bcd_byte_t hour;
	bcd_byte_t days;
	bcd_byte_t weekday_month;
	bcd_year_t year;

	modport clock (output sec, min, hour, days, weekday_month, year);
	modport seq (input sec, min, hour, days, weekday_month, year);
endinterface

/* source/smpc_oreg_ram.sv */
module smpc_oreg_ram (
	input  logic                     CLK,
	input  smpc_bus_pkg::oreg_addr_t wa,
	input  smpc_bus_pkg::bus_data_t  wd,
	input  logic                     we,
	input  smpc_bus_pkg::oreg_addr_t ra,
	output smpc_bus_pkg::bus_data_t  rd
);
	import smpc_bus_pkg::*;

	bus_data_t mem [32];

	always_ff @(posedge CLK) begin
		if (we)
			mem[wa] <= wd;
	end

	assign rd = mem[ra];   // Async read port for the host

	a_we_addr_known: assert property (@(posedge CLK) we |-> !$isunknown(wa))
		else $error("OREG write with unknown address");

endmodule

/* source/smpc_rtc.sv */
`include "smpc_defines.svh"

module smpc_rtc #(
	parameter int TICKS_PER_SEC = `SMPC_TICKS_PER_SEC
) (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      ce,
	smpc_rtc_if.clock rtc
);
	import smpc_cmd_pkg::*;

	localparam int PRE_W = $clog2(TICKS_PER_SEC + 1);

	logic [PRE_W-1:0] pre_cnt;
	logic             sec_tick;
	logic             min_tick;
	logic             hour_tick;
	logic             day_tick;
	logic             month_tick;
	logic             year_tick;
	bcd_byte_t        sec;
	bcd_byte_t        min;
	bcd_byte_t        hour;
	bcd_byte_t        days;
	nibble_t          weekday;
	nibble_t          month;    // Binary 1 to 12
	bcd_year_t        year;
	bcd_byte_t        month_len;

	function automatic bcd_byte_t bcd_next(bcd_byte_t v, bcd_byte_t last, bcd_byte_t first);
		if (v == last)
			return first;
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return v + 8'd1;
	endfunction

	function automatic bcd_year_t year_next(bcd_year_t y);
		bcd_year_t r;
		logic      carry;
		r = y;
		carry = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (carry) begin
				if (r[i*4 +: 4] == 4'd9) begin
					r[i*4 +: 4] = 4'd0;
				end else begin
					r[i*4 +: 4] = r[i*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return r;
	endfunction

	// February fixed at 28
	always_comb begin
		case (month)
			4'd2:                      month_len = 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11:   month_len = 8'h30;
			default:                   month_len = 8'h31;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pre_cnt    <= '0;
			sec_tick   <= 1'b0;
			min_tick   <= 1'b0;
			hour_tick  <= 1'b0;
			day_tick   <= 1'b0;
			month_tick <= 1'b0;
			year_tick  <= 1'b0;
			sec        <= 8'h00;
			min        <= 8'h00;
			hour       <= 8'h00;
			days       <= 8'h01;
			weekday    <= 4'd0;
			month      <= 4'd1;
			year       <= `SMPC_RTC_YEAR_INIT;
		end else if (ce) begin
			sec_tick   <= 1'b0;
			min_tick   <= 1'b0;
			hour_tick  <= 1'b0;
			day_tick   <= 1'b0;
			month_tick <= 1'b0;
			year_tick  <= 1'b0;

			if (pre_cnt == PRE_W'(TICKS_PER_SEC - 1)) begin
				pre_cnt  <= '0;
				sec_tick <= 1'b1;
			end else begin
				pre_cnt <= pre_cnt + PRE_W'(1);
			end

			// One carry stage per CE cycle
			if (sec_tick) begin
				sec      <= bcd_next(sec, 8'h59, 8'h00);
				min_tick <= (sec == 8'h59);
			end
			if (min_tick) begin
				min       <= bcd_next(min, 8'h59, 8'h00);
				hour_tick <= (min == 8'h59);
			end
			if (hour_tick) begin
				hour     <= bcd_next(hour, 8'h23, 8'h00);
				day_tick <= (hour == 8'h23);
			end
			if (day_tick) begin
				days       <= bcd_next(days, month_len, 8'h01);
				weekday    <= (weekday == 4'd6) ? 4'd0 : weekday + 4'd1;
				month_tick <= (days == month_len);
			end
			if (month_tick) begin
				month     <= (month == 4'd12) ? 4'd1 : month + 4'd1;
				year_tick <= (month == 4'd12);
			end
			if (year_tick)
				year <= year_next(year);
		end
	end

	assign rtc.sec           = sec;
	assign rtc.min           = min;
	assign rtc.hour          = hour;
	assign rtc.days          = days;
	assign rtc.weekday_month = {weekday, month};
	assign rtc.year          = year;

endmodule

/* source/smpc_top.sv */
`include "smpc_defines.svh"

module smpc_top #(
	parameter int TICKS_PER_SEC = `SMPC_TICKS_PER_SEC
) (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    CE,
	input  smpc_cmd_pkg::nibble_t   AC,
	input  smpc_bus_pkg::bus_addr_t A,
	input  smpc_bus_pkg::bus_data_t DI,
	output smpc_bus_pkg::bus_data_t DO,
	input  logic                    CS_N,
	input  logic                    RW_N,
	output logic                    MSHRES_N,
	output logic                    MSHNMI_N,
	output logic                    SSHRES_N,
	output logic                    SSHNMI_N,
	output logic                    SNDRES_N,
	output logic                    CDRES_N,
	output logic                    MIRQ_N
);
	import smpc_bus_pkg::*;

	oreg_addr_t oreg_wa;
	bus_data_t  oreg_wd;
	logic       oreg_we;
	oreg_addr_t oreg_ra;
	bus_data_t  oreg_rd;

	smpc_cmd_if cmd_bus ();
	smpc_rtc_if rtc_bus ();

	smpc_host_regs u_host_regs (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.a       (A),
		.di      (DI),
		.cs_n    (CS_N),
		.rw_n    (RW_N),
		.rdata   (DO),
		.oreg_ra (oreg_ra),
		.oreg_rd (oreg_rd),
		.cmd     (cmd_bus)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (CE),
		.ac       (AC),
		.cmd      (cmd_bus),
		.rtc      (rtc_bus),
		.oreg_wa  (oreg_wa),
		.oreg_wd  (oreg_wd),
		.oreg_we  (oreg_we),
		.mshres_n (MSHRES_N),
		.mshnmi_n (MSHNMI_N),
		.sshres_n (SSHRES_N),
		.sshnmi_n (SSHNMI_N),
		.sndres_n (SNDRES_N),
		.cdres_n  (CDRES_N),
		.mirq_n   (MIRQ_N)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK   (CLK),
		.RST_N (RST_N),
		.ce    (CE),
		.rtc   (rtc_bus)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK (CLK),
		.wa  (oreg_wa),
		.wd  (oreg_wd),
		.we  (oreg_we),
		.ra  (oreg_ra),
		.rd  (oreg_rd)
	);

endmodule

/* src.f */
+incdir+source
+incdir+verif
source/smpc_bus_pkg.sv
source/smpc_cmd_pkg.sv
source/smpc_if.sv
source/smpc_oreg_ram.sv
source/smpc_rtc.sv
source/smpc_cmd_seq.sv
source/smpc_host_regs.sv
source/smpc_top.sv
verif/smpc_tb.sv

/* verif/smpc_tb_checks.svh */
`ifndef SMPC_TB_CHECKS_SVH
`define SMPC_TB_CHECKS_SVH

// All bus tasks start and end on a falling edge
task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
	A = addr;
	DI = data;
	CS_N = 1'b0;
	RW_N = 1'b0;
	@(negedge CLK);
	CS_N = 1'b1;
	RW_N = 1'b1;
	@(negedge CLK);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
	A = addr;
	CS_N = 1'b0;
	RW_N = 1'b1;
	@(negedge CLK);
	data = DO;   // Registered on the last rising edge
	CS_N = 1'b1;
	@(negedge CLK);
endtask

task automatic expect_byte(input bus_data_t got, input bus_data_t exp, input string msg);
	chk_got = got;
	chk_exp = exp;
	chk_msg = msg;
	chk_en = 1'b1;
	@(negedge CLK);
	chk_en = 1'b0;
endtask

task automatic expect_true(input logic cond, input string msg);
	expect_byte({7'b0000000, cond}, 8'h01, msg);
endtask

task automatic check_read(input bus_addr_t addr, input bus_data_t exp, input string msg);
	bus_data_t got;
	bus_read(addr, got);
	expect_byte(got, exp, msg);
endtask

task automatic check_lines(input string msg);
	expect_byte({1'b0, MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N, MIRQ_N},
		{1'b0, exp_mshres_n, exp_mshnmi_n, exp_sshres_n, exp_sshnmi_n, exp_sndres_n,
		exp_cdres_n, 1'b1}, msg);
endtask

// Set SF, issue the command, then poll SF until the sequencer clears it
task automatic run_cmd(input cmd_code_e code);
	bus_data_t flag;
	bus_write(ADDR_SF, 8'h01);
	bus_write(ADDR_COMREG, code);
	flag = 8'h01;
	while (flag[0])
		bus_read(ADDR_SF, flag);
endtask

a_value_match: assert property (@(posedge CLK) chk_en |-> (chk_got == chk_exp))
	else report_mismatch(chk_msg, chk_got, chk_exp);

a_irq_only_valid: assert property (@(posedge CLK) disable iff (!RST_N)
	!MIRQ_N |-> irq_allowed)
	else report_mismatch("MIRQ_N low outside a valid INTBACK", {7'b0000000, MIRQ_N}, 8'h01);

`endif

/* verif/smpc_tb.sv */
`include "smpc_defines.svh"

module smpc_tb;
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	localparam int TICKS = 4;
	localparam int TIMEOUT_CYCLES = 60000;
	localparam int MINUTE_CYCLES = 60 * TICKS + 16;   // One RTC minute plus carry ripple
	localparam bit [31:0] SEED = 32'h09a8_0e10;
	localparam bit [15:0] YEAR_RESET = `SMPC_RTC_YEAR_INIT;

	// Host word addresses are the byte addresses shifted right by one
	localparam bus_addr_t ADDR_IREG0 = 6'h00;
	localparam bus_addr_t ADDR_IREG2 = 6'h02;
	localparam bus_addr_t ADDR_COMREG = 6'h0F;
	localparam bus_addr_t ADDR_OREG0 = 6'h10;
	localparam bus_addr_t ADDR_SR = 6'h30;
	localparam bus_addr_t ADDR_SF = 6'h31;

	logic      CLK;
	logic      RST_N;
	logic      CE;
	nibble_t   AC;
	bus_addr_t A;
	bus_data_t DI;
	bus_data_t DO;
	logic      CS_N;
	logic      RW_N;
	logic      MSHRES_N;
	logic      MSHNMI_N;
	logic      SSHRES_N;
	logic      SSHNMI_N;
	logic      SNDRES_N;
	logic      CDRES_N;
	logic      MIRQ_N;

	// Expected line levels after each command
	logic exp_mshres_n;
	logic exp_mshnmi_n;
	logic exp_sshres_n;
	logic exp_sshnmi_n;
	logic exp_sndres_n;
	logic exp_cdres_n;
	logic exp_resd;

	logic        chk_en;
	bus_data_t   chk_got;
	bus_data_t   chk_exp;
	string       chk_msg;
	logic        irq_allowed;   // High only while a valid INTBACK runs
	int unsigned cycle_cnt;
	int unsigned nmi_low_cycle;
	int unsigned irq_low_cycle;

	smpc_top #(
		.TICKS_PER_SEC (TICKS)
	) uut (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.AC       (AC),
		.A        (A),
		.DI       (DI),
		.DO       (DO),
		.CS_N     (CS_N),
		.RW_N     (RW_N),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N)
	);

	always #20 CLK = ~CLK;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic report_mismatch(input string msg, input bus_data_t got, input bus_data_t exp);
		fail_run($sformatf("Error at time %0t: %s (got %02h, expected %02h)",
			$time, msg, got, exp));
	endtask

	// Cycle count since reset and the last cycles NMI and IRQ were seen low
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycle_cnt     <= 0;
			nmi_low_cycle <= 0;
			irq_low_cycle <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
			if (!MSHNMI_N)
				nmi_low_cycle <= cycle_cnt;
			if (!MIRQ_N)
				irq_low_cycle <= cycle_cnt;
			if (cycle_cnt >= TIMEOUT_CYCLES)
				fail_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
					TIMEOUT_CYCLES));
		end
	end

	`include "smpc_tb_checks.svh"

	task automatic apply_exec_rule(input cmd_code_e code);
		case (code)
			CMD_MSHON: begin
				exp_mshres_n = 1'b1;
				exp_mshnmi_n = 1'b1;
			end
			CMD_SSHON: begin
				exp_sshres_n = 1'b1;
				exp_sshnmi_n = 1'b1;
			end
			CMD_SSHOFF: begin
				exp_sshres_n = 1'b0;
				exp_sshnmi_n = 1'b1;
			end
			CMD_SNDON:   exp_sndres_n = 1'b1;
			CMD_SNDOFF:  exp_sndres_n = 1'b0;
			CMD_CDON:    exp_cdres_n = 1'b1;
			CMD_CDOFF:   exp_cdres_n = 1'b0;
			CMD_RESENAB: exp_resd = 1'b0;
			CMD_RESDISA: exp_resd = 1'b1;
			default: ;   // NMIREQ ends with MSHNMI_N high again
		endcase
	endtask

	function automatic bus_data_t expected_oreg(input int idx);
		case (idx)
			0:  return {1'b0, exp_resd, 6'b000000};
			1:  return YEAR_RESET[15:8];
			2:  return YEAR_RESET[7:0];
			3:  return 8'h01;   // Weekday 0 and month 1
			4:  return 8'h01;
			9:  return {4'h0, AC};
			// Bits 5, 4 and 2 are fixed ones
			10: return 8'h34 | {4'b0000, ~exp_mshnmi_n, 3'b000} | {7'b0000000, ~exp_sndres_n};
			11: return {1'b0, ~exp_cdres_n, 6'b000000};
			`SMPC_OREG_LAST: return CMD_INTBACK;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic bcd_in_range(input bus_data_t v, input bus_data_t max);
		return (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9) && (v <= max);
	endfunction

	task automatic check_power_cmd(input cmd_code_e code);
		run_cmd(code);
		apply_exec_rule(code);
		check_lines($sformatf("output lines after command %02h", code));
		check_read(ADDR_OREG0 + 6'(`SMPC_OREG_LAST), code, "OREG31 command echo");
	endtask

	task automatic run_intback();
		irq_allowed = 1'b1;
		run_cmd(CMD_INTBACK);
		irq_allowed = 1'b0;
	endtask

	task automatic check_intback_result();
		bus_data_t got;
		for (int i = 0; i <= `SMPC_OREG_LAST; i++) begin
			bus_read(ADDR_OREG0 + 6'(i), got);
			case (i)
				5: expect_true(bcd_in_range(got, 8'h23), "OREG5 hour is not BCD 00 to 23");
				6: begin
					expect_true(bcd_in_range(got, 8'h59), "OREG6 minute is not BCD 00 to 59");
					expect_true(got >= 8'h01, "OREG6 minute still 00 after a full minute");
				end
				7: expect_true(bcd_in_range(got, 8'h59), "OREG7 second is not BCD 00 to 59");
				default: expect_byte(got, expected_oreg(i), $sformatf("OREG%0d after INTBACK", i));
			endcase
		end
	endtask

	initial begin
		int unsigned start;
		void'($urandom(SEED));
		CLK = 1'b0;
		RST_N = 1'b0;
		CE = 1'b1;
		AC = nibble_t'($urandom);
		A = '0;
		DI = '0;
		CS_N = 1'b1;
		RW_N = 1'b1;
		chk_en = 1'b0;
		chk_got = '0;
		chk_exp = '0;
		chk_msg = "";
		irq_allowed = 1'b0;
		exp_mshres_n = 1'b0;
		exp_mshnmi_n = 1'b0;
		exp_sshres_n = 1'b0;
		exp_sshnmi_n = 1'b0;
		exp_sndres_n = 1'b0;
		exp_cdres_n = 1'b0;
		exp_resd = 1'b1;
		repeat (2) @(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);

		check_lines("output lines after reset");
		check_read(ADDR_SF, 8'h00, "SF after reset");
		check_read(ADDR_SR, 8'h00, "SR after reset");

		check_power_cmd(CMD_MSHON);
		check_power_cmd(CMD_SSHON);
		check_power_cmd(CMD_SSHOFF);
		check_power_cmd(CMD_SNDON);
		check_power_cmd(CMD_SNDOFF);
		check_power_cmd(CMD_CDON);
		check_power_cmd(CMD_CDOFF);

		start = cycle_cnt;
		check_power_cmd(CMD_NMIREQ);
		expect_true(nmi_low_cycle >= start, "MSHNMI_N never pulsed low during NMIREQ");

		// Valid INTBACK parameters
		bus_write(ADDR_IREG0, 8'h01);
		bus_write(ADDR_IREG2, 8'hF0);
		check_power_cmd(CMD_RESENAB);
		run_intback();
		check_read(ADDR_OREG0, 8'h00, "OREG0 after RESENAB");
		check_power_cmd(CMD_RESDISA);
		run_intback();
		check_read(ADDR_OREG0, 8'h40, "OREG0 after RESDISA");

		while (cycle_cnt < MINUTE_CYCLES)
			@(negedge CLK);
		start = cycle_cnt;
		run_intback();
		expect_true(irq_low_cycle >= start, "MIRQ_N did not pulse low before SF fell");
		check_read(ADDR_SR, 8'h4F, "SR after INTBACK");
		check_lines("output lines after INTBACK");
		check_intback_result();

		// Invalid INTBACK leaves the previous echo in OREG31
		check_power_cmd(CMD_SNDON);
		bus_write(ADDR_IREG2, 8'h00);
		run_cmd(CMD_INTBACK);
		check_read(ADDR_OREG0 + 6'(`SMPC_OREG_LAST), CMD_SNDON, "OREG31 after invalid INTBACK");

		$display("Result: PASSED");
		$finish;
	end

endmodule
